/* files.f */
hand_pkg.sv
button_arm.sv
hand_cfg_regs.sv
hand_tracker.sv
hand_controller.sv
hand_props.sv
tb_hand_controller.sv

/* Makefile */
# Verilator build for the hand controller testbench.

VERILATOR ?= verilator
TOP       ?= tb_hand_controller
SEED      ?= 20
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= NO ERRORS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -j 0 \
		-GSEED=$(SEED) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb_hand_controller.sv */
module tb_hand_controller import hand_pkg::*; #(
    parameter int SEED = 20
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_X = 3400;
    localparam int MAX_Y = 3400;
    localparam int MAX_Z = 500;
    localparam hand_pos_t HOME_POS = '{x: 12'd1800, y: 12'd1800, z: 14'd0};

    logic       clk_in;
    logic       rst_in;
    pad_t       pad;
    logic       hand_sel_bottom;
    logic       cfg_wr;
    axis_e      cfg_addr;
    logic [7:0] cfg_data;
    hand_pos_t  hand_bottom;
    hand_pos_t  hand_top;

    // reference model state.
    logic      m_armed;
    logic      m_valid;
    move_cmd_t m_cmd;
    step_cfg_t m_steps;
    hand_pos_t m_bottom;
    hand_pos_t m_top;

    int seed;
    int err_count;
    int check_count;
    int test_count;
    int test_base;

    hand_controller #(.MAX_X(MAX_X), .MAX_Y(MAX_Y), .MAX_Z(MAX_Z)) UUT (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .pad             (pad),
        .hand_sel_bottom (hand_sel_bottom),
        .cfg_wr          (cfg_wr),
        .cfg_addr        (cfg_addr),
        .cfg_data        (cfg_data),
        .hand_bottom     (hand_bottom),
        .hand_top        (hand_top)
    );

    bind hand_controller hand_props #(.MAX_X(MAX_X), .MAX_Y(MAX_Y), .MAX_Z(MAX_Z)) u_hand_props (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .pad         (pad),
        .move_valid  (move_valid),
        .armed       (u_button_arm.armed),
        .hand_bottom (hand_bottom),
        .hand_top    (hand_top)
    );

    initial begin
        clk_in = 1'b1; // first edge is a falling one.
        forever #4 clk_in = ~clk_in;
    end

    // ========================================
    // reference model
    // ========================================

    function automatic dir_e press_dir(input logic neg, input logic pos);
        if (neg) begin
            return DIR_NEG;
        end else if (pos) begin
            return DIR_POS;
        end
        return DIR_NONE;
    endfunction

    function automatic move_cmd_t cmd_from_pad(input pad_t p, input logic sel);
        move_cmd_t c;
        c.dx     = press_dir(p.left, p.right);
        c.dy     = press_dir(p.up, p.down);
        c.dz     = press_dir(p.near, p.far);
        c.bottom = sel;
        return c;
    endfunction

    function automatic int wrap_axis(input int pos, input dir_e dir, input int step,
                                     input int limit);
        int delta;
        int sum;
        if (dir == DIR_NONE) begin
            return pos;
        end
        delta = (dir == DIR_NEG) ? -step : step;
        sum   = pos + delta;
        if (sum >= limit) begin
            return delta;
        end else if (sum < 0) begin
            return limit + delta;
        end
        return sum;
    endfunction

    function automatic hand_pos_t moved_pos(input hand_pos_t p, input move_cmd_t c,
                                            input step_cfg_t s);
        hand_pos_t r;
        r.x = 12'(wrap_axis(int'(p.x), c.dx, int'(s.step_x), MAX_X));
        r.y = 12'(wrap_axis(int'(p.y), c.dy, int'(s.step_y), MAX_Y));
        r.z = 14'(wrap_axis(int'(p.z), c.dz, int'(s.step_z), MAX_Z));
        return r;
    endfunction

    // advances the model over the coming rising edge.
    task automatic model_edge();
        logic pressed;
        pressed = (pad != '0);
        if (rst_in) begin
            m_armed  = 1'b0;
            m_valid  = 1'b0;
            m_steps  = '{8'd16, 8'd16, 8'd16};
            m_bottom = HOME_POS;
            m_top    = HOME_POS;
        end else begin
            if (m_valid && m_cmd.bottom) begin
                m_bottom = moved_pos(m_bottom, m_cmd, m_steps);
            end else if (m_valid) begin
                m_top = moved_pos(m_top, m_cmd, m_steps);
            end
            if (cfg_wr) begin
                case (cfg_addr)
                    AXIS_X:  m_steps.step_x = cfg_data;
                    AXIS_Y:  m_steps.step_y = cfg_data;
                    AXIS_Z:  m_steps.step_z = cfg_data;
                    default: ;
                endcase
            end
            if (m_armed && pressed) begin
                m_valid = 1'b1;
                m_cmd   = cmd_from_pad(pad, hand_sel_bottom);
                m_armed = 1'b0;
            end else begin
                m_valid = 1'b0;
                if (!pressed) begin
                    m_armed = 1'b1;
                end
            end
        end
    endtask

    // ========================================
    // checks and stimulus
    // ========================================

    task automatic check_pos(input string name, input hand_pos_t got, input hand_pos_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %0d,%0d,%0d expected %0d,%0d,%0d", $time, name,
                     got.x, got.y, got.z, exp.x, exp.y, exp.z);
        end
    endtask

    task automatic check_steps(input string name, input step_cfg_t got, input step_cfg_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %0d,%0d,%0d expected %0d,%0d,%0d", $time, name,
                     got.step_x, got.step_y, got.step_z, exp.step_x, exp.step_y, exp.step_z);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic pad_t rand_pad();
        pad_t p;
        p = pad_t'(6'($random(seed)));
        if (p == '0) begin
            p.far = 1'b1;
        end
        return p;
    endfunction

    function automatic pad_t axis_pad(input int axis, input logic pos);
        pad_t p;
        p = '0;
        case (axis)
            0: begin
                p.right = pos;
                p.left  = !pos;
            end
            1: begin
                p.down = pos;
                p.up   = !pos;
            end
            default: begin
                p.far  = pos;
                p.near = !pos;
            end
        endcase
        return p;
    endfunction

    // compare on the falling edge, then drive for the next rising edge.
    task automatic drive_cycle(input pad_t p, input logic sel, input logic wr,
                               input axis_e addr, input logic [7:0] data);
        @(negedge clk_in);
        check_pos("hand_bottom", hand_bottom, m_bottom);
        check_pos("hand_top", hand_top, m_top);
        check_steps("steps", UUT.steps, m_steps);
        rst_in          = 1'b0;
        pad             = p;
        hand_sel_bottom = sel;
        cfg_wr          = wr;
        cfg_addr        = addr;
        cfg_data        = data;
        model_edge();
    endtask

    task automatic apply_reset(input pad_t hold);
        repeat (2) begin
            @(negedge clk_in);
            rst_in = 1'b1;
            pad    = hold;
            cfg_wr = 1'b0;
            model_edge();
        end
    endtask

    task automatic write_step(input axis_e addr, input logic [7:0] data);
        drive_cycle('0, 1'b0, 1'b1, addr, data);
    endtask

    task automatic wait_for_pos(input logic bottom, input hand_pos_t exp, input int limit);
        int n;
        n = 0;
        while (((bottom ? hand_bottom : hand_top) !== exp) && n < limit) begin
            drive_cycle('0, bottom, 1'b0, AXIS_X, 8'd0);
            n++;
        end
        if ((bottom ? hand_bottom : hand_top) !== exp) begin
            err_count++;
            $display("timeout: %s hand did not reach its expected position in %0d cycles",
                     bottom ? "bottom" : "top", limit);
        end
    endtask

    // first pad on the sampled edge, late pad for the rest of the hold.
    task automatic press_and_wait(input pad_t first, input pad_t late, input logic sel,
                                  input int hold);
        hand_pos_t exp;
        drive_cycle('0, sel, 1'b0, AXIS_X, 8'd0); // full release arms the pad.
        exp = moved_pos(sel ? m_bottom : m_top, cmd_from_pad(first, sel), m_steps);
        drive_cycle(first, sel, 1'b0, AXIS_X, 8'd0);
        for (int i = 1; i < hold; i++) begin
            drive_cycle(late, sel, 1'b0, AXIS_X, 8'd0);
        end
        drive_cycle('0, sel, 1'b0, AXIS_X, 8'd0);
        wait_for_pos(sel, exp, 8);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - test_base);
        test_base = err_count;
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial begin
        pad_t p;
        int   total;
        seed            = SEED;
        err_count       = 0;
        check_count     = 0;
        test_count      = 0;
        test_base       = 0;
        rst_in          = 1'b1;
        pad             = '0;
        hand_sel_bottom = 1'b0;
        cfg_wr          = 1'b0;
        cfg_addr        = AXIS_X;
        cfg_data        = 8'd0;

        p      = '0;
        p.left = 1'b1;
        apply_reset(p); // left held through reset.
        check_pos("hand_bottom", hand_bottom, HOME_POS);
        check_pos("hand_top", hand_top, HOME_POS);
        repeat (2 + rand_below(4)) begin
            drive_cycle(p, 1'b1, 1'b0, AXIS_X, 8'd0);
        end
        check_pos("hand_bottom", hand_bottom, HOME_POS);
        check_pos("hand_top", hand_top, HOME_POS);
        press_and_wait(p, p, 1'b1, 1);
        end_test("reset");

        repeat (40) begin
            p = rand_pad();
            press_and_wait(p, p, 1'(rand_below(2)), 1);
        end
        end_test("single press");

        repeat (20) begin
            p = rand_pad();
            press_and_wait(p, rand_pad(), 1'(rand_below(2)), 2 + rand_below(8));
        end
        end_test("held press");

        write_step(AXIS_X, 8'(150 + rand_below(100)));
        write_step(AXIS_Y, 8'(150 + rand_below(100)));
        write_step(AXIS_Z, 8'(150 + rand_below(100)));
        // one hand per direction, so every run crosses the whole axis.
        for (int axis = 0; axis < 3; axis++) begin
            for (int dir = 0; dir < 2; dir++) begin
                repeat (25) begin
                    p = axis_pad(axis, dir == 1);
                    press_and_wait(p, p, 1'(dir), 1);
                end
            end
        end
        end_test("wrap");

        repeat (12) begin
            write_step(axis_e'(2'(rand_below(3))), 8'($random(seed)));
            p = rand_pad();
            press_and_wait(p, p, 1'(rand_below(2)), 1);
        end
        end_test("config");

        repeat (400) begin
            p = (rand_below(2) == 0) ? pad_t'(6'd0) : rand_pad();
            drive_cycle(p, 1'(rand_below(2)), rand_below(10) == 0,
                        axis_e'(2'(rand_below(3))), 8'($random(seed)));
        end
        repeat (3) begin
            drive_cycle('0, 1'b0, 1'b0, AXIS_X, 8'd0);
        end
        end_test("random run");

        total = err_count + int'(UUT.u_hand_props.fail_count);
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* hand_props.sv */
module hand_props import hand_pkg::*; #(
    parameter int MAX_X = 3400,
    parameter int MAX_Y = 3400,
    parameter int MAX_Z = 500
) (
    input logic      clk_in,
    input logic      rst_in,
    input pad_t      pad,
    input logic      move_valid,
    input logic      armed,
    input hand_pos_t hand_bottom,
    input hand_pos_t hand_top
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // summed into the final error count.

    a_single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        move_valid |=> !move_valid)
    else begin
        $error("move_valid high on two consecutive cycles");
        fail_count++;
    end

    a_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
        int'(hand_bottom.x) < MAX_X && int'(hand_bottom.y) < MAX_Y &&
        int'(hand_bottom.z) < MAX_Z && int'(hand_top.x) < MAX_X &&
        int'(hand_top.y) < MAX_Y && int'(hand_top.z) < MAX_Z)
    else begin
        $error("hand coordinate at or above its limit");
        fail_count++;
    end

    a_armed_source: assert property (@(posedge clk_in) disable iff (rst_in)
        move_valid |-> $past(armed && (pad != '0)))
    else begin
        $error("move_valid without an armed press on the previous cycle");
        fail_count++;
    end

endmodule

/* hand_controller.sv */
module hand_controller import hand_pkg::*; #(
    parameter int MAX_X = 3400,
    parameter int MAX_Y = 3400,
    parameter int MAX_Z = 500
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  pad_t       pad,
    input  logic       hand_sel_bottom,
    input  logic       cfg_wr,
    input  axis_e      cfg_addr,
    input  logic [7:0] cfg_data,
    output hand_pos_t  hand_bottom,
    output hand_pos_t  hand_top
);

    logic      move_valid;
    move_cmd_t move_cmd;
    step_cfg_t steps;

    // one command per press.
    button_arm u_button_arm (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .pad             (pad),
        .hand_sel_bottom (hand_sel_bottom),
        .move_valid      (move_valid),
        .move_cmd        (move_cmd)
    );

    hand_cfg_regs u_hand_cfg_regs (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .steps    (steps)
    );

    hand_tracker #(
        .MAX_X (MAX_X),
        .MAX_Y (MAX_Y),
        .MAX_Z (MAX_Z)
    ) u_hand_tracker (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .move_valid  (move_valid),
        .move_cmd    (move_cmd),
        .steps       (steps),
        .hand_bottom (hand_bottom),
        .hand_top    (hand_top)
    );

endmodule

/* hand_tracker.sv */
module hand_tracker import hand_pkg::*; #(
    parameter int MAX_X = 3400,
    parameter int MAX_Y = 3400,
    parameter int MAX_Z = 500
) (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      move_valid,
    input  move_cmd_t move_cmd,
    input  step_cfg_t steps,
    output hand_pos_t hand_bottom,
    output hand_pos_t hand_top
);

    hand_pos_t   sel_pos;
    hand_pos_t   next_pos;
    logic [13:0] next_x;
    logic [13:0] next_y;
    logic [13:0] next_z;

    // ========================================
    // wrap-around coordinate update
    // ========================================

    // signed step for one axis, zero when the axis does not move.
    function automatic int signed_step(input dir_e dir, input logic [7:0] step);
        int delta;
        delta = int'(step);
        case (dir)
            DIR_NEG: return -delta;
            DIR_POS: return delta;
            default: return 0;
        endcase
    endfunction

    // overflow restarts at the step, underflow counts back from the limit.
    function automatic logic [13:0] wrap_coord(
        input logic [13:0] pos,
        input dir_e        dir,
        input logic [7:0]  step,
        input int          limit
    );
        int delta;
        int sum;
        delta = signed_step(dir, step);
        sum   = int'(pos) + delta;
        if (dir == DIR_NONE) begin
            return pos;
        end else if (sum >= limit) begin
            return 14'(delta);
        end else if (sum < 0) begin
            return 14'(limit + delta);
        end
        return 14'(sum);
    endfunction

    // ========================================
    // next position of the selected hand
    // ========================================

    always_comb begin
        if (move_cmd.bottom) begin
            sel_pos = hand_bottom;
        end else begin
            sel_pos = hand_top;
        end
    end

    always_comb begin
        next_x = wrap_coord({2'b00, sel_pos.x}, move_cmd.dx, steps.step_x, MAX_X);
        next_y = wrap_coord({2'b00, sel_pos.y}, move_cmd.dy, steps.step_y, MAX_Y);
        next_z = wrap_coord(sel_pos.z, move_cmd.dz, steps.step_z, MAX_Z);
    end

    always_comb begin
        next_pos.x = next_x[11:0]; // limit fits in 12 bits.
        next_pos.y = next_y[11:0];
        next_pos.z = next_z;
    end

    // ========================================
    // position registers
    // ========================================

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hand_bottom.x <= HOME_X;
            hand_bottom.y <= HOME_Y;
            hand_bottom.z <= HOME_Z;
        end else if (move_valid && move_cmd.bottom) begin
            hand_bottom <= next_pos;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hand_top.x <= HOME_X;
            hand_top.y <= HOME_Y;
            hand_top.z <= HOME_Z;
        end else if (move_valid && !move_cmd.bottom) begin
            hand_top <= next_pos;
        end
    end

endmodule

/* hand_cfg_regs.sv */
module hand_cfg_regs import hand_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       cfg_wr,
    input  axis_e      cfg_addr,
    input  logic [7:0] cfg_data,
    output step_cfg_t  steps
);

    logic [7:0] step_x;
    logic [7:0] step_y;
    logic [7:0] step_z;

    logic wr_x;
    logic wr_y;
    logic wr_z;

    // ========================================
    // address decode
    // ========================================

    always_comb begin
        wr_x = 1'b0;
        wr_y = 1'b0;
        wr_z = 1'b0;
        if (cfg_wr) begin
            case (cfg_addr)
                AXIS_X:  wr_x = 1'b1;
                AXIS_Y:  wr_y = 1'b1;
                AXIS_Z:  wr_z = 1'b1;
                default: ; // unused address, write dropped.
            endcase
        end
    end

    // ========================================
    // step registers
    // ========================================

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            step_x <= STEP_DEFAULT;
            step_y <= STEP_DEFAULT;
            step_z <= STEP_DEFAULT;
        end else begin
            if (wr_x) begin
                step_x <= cfg_data;
            end
            if (wr_y) begin
                step_y <= cfg_data;
            end
            if (wr_z) begin
                step_z <= cfg_data;
            end
        end
    end

    assign steps.step_x = step_x;
    assign steps.step_y = step_y;
    assign steps.step_z = step_z;

endmodule

/* button_arm.sv */
module button_arm import hand_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  pad_t      pad,
    input  logic      hand_sel_bottom,
    output logic      move_valid,
    output move_cmd_t move_cmd
);

    logic      armed;
    logic      any_pressed;
    move_cmd_t next_cmd;

    // the negative button of a pair wins when both are held.
    function automatic dir_e pick_dir(input logic neg, input logic pos);
        if (neg) begin
            return DIR_NEG;
        end else if (pos) begin
            return DIR_POS;
        end
        return DIR_NONE;
    endfunction

    assign any_pressed = |pad;

    always_comb begin
        next_cmd.dx     = pick_dir(pad.left, pad.right);
        next_cmd.dy     = pick_dir(pad.up, pad.down);
        next_cmd.dz     = pick_dir(pad.near, pad.far);
        next_cmd.bottom = hand_sel_bottom;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            armed      <= 1'b0; // held buttons must be released after reset.
            move_valid <= 1'b0;
        end else begin
            move_valid <= armed && any_pressed;
            if (armed && any_pressed) begin
                armed <= 1'b0;
            end else if (!any_pressed) begin
                armed <= 1'b1; // full release.
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (armed && any_pressed) begin
            move_cmd <= next_cmd;
        end
    end

endmodule

/* hand_pkg.sv */
package hand_pkg;

    // ========================================
    // player pad and configuration
    // ========================================

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic near;
        logic far;
    } pad_t;

    typedef enum logic [1:0] {
        AXIS_X,
        AXIS_Y,
        AXIS_Z
    } axis_e;

    typedef struct packed {
        logic [7:0] step_x;
        logic [7:0] step_y;
        logic [7:0] step_z;
    } step_cfg_t;

    // ========================================
    // move command and hand position
    // ========================================

    typedef enum logic [1:0] {
        DIR_NONE,
        DIR_NEG,
        DIR_POS
    } dir_e;

    typedef struct packed {
        dir_e dx;
        dir_e dy;
        dir_e dz;
        logic bottom; // 1 selects the bottom hand.
    } move_cmd_t;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [13:0] z;
    } hand_pos_t;

    localparam logic [11:0] HOME_X = 12'd1800;
    localparam logic [11:0] HOME_Y = 12'd1800;
    localparam logic [13:0] HOME_Z = 14'd0;
    localparam logic [7:0] STEP_DEFAULT = 8'd16;

endpackage
